// File: Bender.yml
package:
  name: l2_mshr

export_include_dirs:
  - .

sources:
  - l2_mshr_pkg.sv
  - mshr_entry.sv
  - mshr_table.sv
  - mshr_query.sv
  - l2_mshr.sv
  - target: test
    files:
      - l2_mshr_properties.sv
      - tb_l2_mshr.sv

// File: compile.f
+incdir+.
l2_mshr_pkg.sv
mshr_entry.sv
mshr_table.sv
mshr_query.sv
l2_mshr.sv
l2_mshr_properties.sv
tb_l2_mshr.sv

// File: l2_mshr.sv
`include "l2_mshr_consts.svh"

module l2_mshr import l2_mshr_pkg::*; (
    input logic clk,
    input logic rst,
    // query select from the L2 controller
    input mshr_op_t op,
    input addr_t req_addr,
    input addr_t line_addr,
    // write strobes, all target mshr_i
    input logic add_entry,
    input logic update_state,
    input logic update_line,
    input logic update_tag,
    input logic update_word_mask,
    // write values
    input cpu_msg_t cpu_msg,
    input l2_way_t way,
    input hsize_t hsize,
    input hprot_t hprot,
    input word_t word,
    input l2_tag_t tag,
    input line_t line,
    input word_mask_t word_mask,
    input unstable_state_t state,
    // table contents
    output mshr_buf_t entries [`N_MSHR],
    // query results
    output logic mshr_hit_next,
    output logic mshr_hit,
    output mshr_index_t mshr_i_next,
    output mshr_index_t mshr_i,
    output logic set_conflict,
    output logic clr_conflict,
    output logic set_fwd_stall,
    output logic clr_fwd_stall,
    output logic set_fwd_stall_entry,
    output mshr_index_t fwd_stall_entry
);

    // storage, written at the registered index
    mshr_table u_table (
        .clk(clk),
        .rst(rst),
        .add_entry(add_entry),
        .update_state(update_state),
        .update_line(update_line),
        .update_tag(update_tag),
        .update_word_mask(update_word_mask),
        .req_addr(req_addr),
        .mshr_i(mshr_i),
        .cpu_msg(cpu_msg),
        .way(way),
        .hsize(hsize),
        .hprot(hprot),
        .word(word),
        .tag(tag),
        .line(line),
        .word_mask(word_mask),
        .state(state),
        .entries(entries)
    );

    // search and result register
    mshr_query u_query (
        .clk(clk),
        .rst(rst),
        .op(op),
        .req_addr(req_addr),
        .line_addr(line_addr),
        .entries(entries),
        .mshr_hit_next(mshr_hit_next),
        .mshr_hit(mshr_hit),
        .mshr_i_next(mshr_i_next),
        .mshr_i(mshr_i),
        .set_conflict(set_conflict),
        .clr_conflict(clr_conflict),
        .set_fwd_stall(set_fwd_stall),
        .clr_fwd_stall(clr_fwd_stall),
        .set_fwd_stall_entry(set_fwd_stall_entry),
        .fwd_stall_entry(fwd_stall_entry)
    );

endmodule

// File: l2_mshr_consts.svh
`ifndef L2_MSHR_CONSTS_SVH
`define L2_MSHR_CONSTS_SVH

// table size and index width
`define N_MSHR 4
`define MSHR_BITS 2

// op codes driven by the L2 controller FSM
`define MSHR_OP_BITS 3
`define L2_MSHR_IDLE 3'd0
`define L2_MSHR_LOOKUP 3'd1
`define L2_MSHR_PEEK_REQ 3'd2
`define L2_MSHR_PEEK_FWD 3'd3

// address breakdown, tag | set | word | byte
`define ADDR_BITS 32
`define BYTE_BITS 2
`define WORD_BITS 2
`define SET_BITS 8
`define TAG_BITS 20

// data and field widths
`define WORDS_PER_LINE 4
`define BITS_PER_WORD 32
`define WAY_BITS 3
`define STATE_BITS 3
`define CPU_MSG_BITS 2
`define HSIZE_BITS 3
`define HPROT_BITS 2

// invalid coherence state, marks a free entry
`define SPX_I 3'd0

`endif

// File: l2_mshr_pkg.sv
`include "l2_mshr_consts.svh"

package l2_mshr_pkg;

    // address and its fields
    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`TAG_BITS-1:0] l2_tag_t;
    typedef logic [`SET_BITS-1:0] l2_set_t;
    typedef logic [`WORD_BITS-1:0] w_off_t;
    typedef logic [`BYTE_BITS-1:0] b_off_t;

    // cache way of the pending fill
    typedef logic [`WAY_BITS-1:0] l2_way_t;

    // data payloads
    typedef logic [`BITS_PER_WORD-1:0] word_t;
    typedef logic [`WORDS_PER_LINE*`BITS_PER_WORD-1:0] line_t;
    // one bit per word of a line
    typedef logic [`WORDS_PER_LINE-1:0] word_mask_t;

    // transient coherence state
    typedef logic [`STATE_BITS-1:0] unstable_state_t;

    // request attributes from the cpu side
    typedef logic [`CPU_MSG_BITS-1:0] cpu_msg_t;
    typedef logic [`HSIZE_BITS-1:0] hsize_t;
    typedef logic [`HPROT_BITS-1:0] hprot_t;

    // query select and table index
    typedef logic [`MSHR_OP_BITS-1:0] mshr_op_t;
    typedef logic [`MSHR_BITS-1:0] mshr_index_t;

    // one outstanding miss
    // live whenever state is not SPX_I
    typedef struct packed {
        cpu_msg_t cpu_msg;
        l2_tag_t tag;
        l2_set_t set;
        l2_way_t way;
        hsize_t hsize;
        w_off_t w_off;
        b_off_t b_off;
        hprot_t hprot;
        word_t word;
        line_t line;
        word_mask_t word_mask;
        unstable_state_t state;
    } mshr_buf_t;

endpackage

// File: l2_mshr_properties.sv
`include "l2_mshr_consts.svh"

module l2_mshr_properties import l2_mshr_pkg::*; (
    input logic clk,
    input logic rst,
    input mshr_op_t op,
    input logic mshr_hit_next,
    input logic mshr_hit,
    input mshr_index_t mshr_i,
    input logic set_conflict,
    input logic clr_conflict,
    input logic set_fwd_stall,
    input logic clr_fwd_stall,
    input logic set_fwd_stall_entry
);

    // peek request answers one way only
    a_conflict_excl: assert property (@(posedge clk) disable iff (!rst)
        !(set_conflict && clr_conflict))
        else $error("set_conflict and clr_conflict high together");

    // stall entry only with the stall itself
    a_stall_entry: assert property (@(posedge clk) disable iff (!rst)
        set_fwd_stall_entry |-> set_fwd_stall)
        else $error("set_fwd_stall_entry without set_fwd_stall");

    // idle query, all flags low
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst)
        (op == `L2_MSHR_IDLE) |-> !(mshr_hit_next || set_conflict || clr_conflict
            || set_fwd_stall || clr_fwd_stall || set_fwd_stall_entry))
        else $error("query flag high while op is idle");

    // registered result holds across idle
    a_idle_hold: assert property (@(posedge clk) disable iff (!rst)
        (op == `L2_MSHR_IDLE) |=> ($stable(mshr_i) && $stable(mshr_hit)))
        else $error("mshr_i or mshr_hit changed after an idle cycle");

endmodule

bind l2_mshr l2_mshr_properties u_properties (
    .clk(clk),
    .rst(rst),
    .op(op),
    .mshr_hit_next(mshr_hit_next),
    .mshr_hit(mshr_hit),
    .mshr_i(mshr_i),
    .set_conflict(set_conflict),
    .clr_conflict(clr_conflict),
    .set_fwd_stall(set_fwd_stall),
    .clr_fwd_stall(clr_fwd_stall),
    .set_fwd_stall_entry(set_fwd_stall_entry)
);

// File: mshr_entry.sv
`include "l2_mshr_consts.svh"

module mshr_entry import l2_mshr_pkg::*; (
    input logic clk,
    input logic rst,
    // this entry is the one at mshr_i
    input logic sel,
    // write strobes
    input logic add_entry,
    input logic update_state,
    input logic update_line,
    input logic update_tag,
    input logic update_word_mask,
    // values, set and offsets already split from req_addr
    input cpu_msg_t cpu_msg,
    input l2_set_t set,
    input w_off_t w_off,
    input b_off_t b_off,
    input l2_way_t way,
    input hsize_t hsize,
    input hprot_t hprot,
    input word_t word,
    input l2_tag_t tag,
    input line_t line,
    input word_mask_t word_mask,
    input unstable_state_t state,
    output mshr_buf_t entry
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // all zero, state SPX_I, so the entry starts free
            entry <= '0;
        end else if (sel) begin
            if (add_entry) begin
                // allocate, every field loaded
                entry.cpu_msg <= cpu_msg;
                entry.set <= set;
                entry.w_off <= w_off;
                entry.b_off <= b_off;
                entry.way <= way;
                entry.hsize <= hsize;
                entry.hprot <= hprot;
                entry.word <= word;
                // add also covers the separately updatable fields
                entry.tag <= tag;
                entry.line <= line;
                entry.word_mask <= word_mask;
                entry.state <= state;
            end else begin
                // single field rewrites
                if (update_state) begin
                    entry.state <= state;
                end
                if (update_line) begin
                    entry.line <= line;
                end
                if (update_tag) begin
                    entry.tag <= tag;
                end
                if (update_word_mask) begin
                    entry.word_mask <= word_mask;
                end
            end
        end
    end

endmodule

// File: mshr_query.sv
`include "l2_mshr_consts.svh"

module mshr_query import l2_mshr_pkg::*; (
    input logic clk,
    input logic rst,
    input mshr_op_t op,
    // new request address, for peek request
    input addr_t req_addr,
    // searched line, for lookup and peek forward
    input addr_t line_addr,
    input mshr_buf_t entries [`N_MSHR],
    output logic mshr_hit_next,
    output logic mshr_hit,
    output mshr_index_t mshr_i_next,
    output mshr_index_t mshr_i,
    output logic set_conflict,
    output logic clr_conflict,
    output logic set_fwd_stall,
    output logic clr_fwd_stall,
    output logic set_fwd_stall_entry,
    output mshr_index_t fwd_stall_entry
);

    // fields used for matching
    l2_set_t req_set;
    l2_tag_t line_tag;
    l2_set_t line_set;

    // per-entry match vectors
    logic [`N_MSHR-1:0] live;
    logic [`N_MSHR-1:0] line_match;
    logic [`N_MSHR-1:0] set_match;

    assign req_set = req_addr[`BYTE_BITS+`WORD_BITS +: `SET_BITS];
    assign line_set = line_addr[`BYTE_BITS+`WORD_BITS +: `SET_BITS];
    assign line_tag = line_addr[`ADDR_BITS-1 -: `TAG_BITS];

    always_comb begin
        for (int i = 0; i < `N_MSHR; i++) begin
            live[i] = (entries[i].state != `SPX_I);
            // same line, tag and set both equal
            line_match[i] = live[i] && (entries[i].tag == line_tag)
                && (entries[i].set == line_set);
            // set only, tag ignored
            set_match[i] = live[i] && (entries[i].set == req_set);
        end
    end

    // query decode, no clock
    // ascending loops so the highest index is written last and wins
    always_comb begin
        mshr_hit_next = 1'b0;
        mshr_i_next = '0;
        set_conflict = 1'b0;
        clr_conflict = 1'b0;
        set_fwd_stall = 1'b0;
        clr_fwd_stall = 1'b0;
        set_fwd_stall_entry = 1'b0;
        fwd_stall_entry = '0;

        case (op)
            `L2_MSHR_LOOKUP: begin
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (line_match[i]) begin
                        mshr_hit_next = 1'b1;
                        mshr_i_next = mshr_index_t'(i);
                    end
                end
            end
            `L2_MSHR_PEEK_REQ: begin
                // free slot for the allocate that follows
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (!live[i]) begin
                        mshr_i_next = mshr_index_t'(i);
                    end
                end
                // any live entry in the same set blocks the request
                if (|set_match) begin
                    set_conflict = 1'b1;
                end else begin
                    clr_conflict = 1'b1;
                end
            end
            `L2_MSHR_PEEK_FWD: begin
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (line_match[i]) begin
                        mshr_hit_next = 1'b1;
                        mshr_i_next = mshr_index_t'(i);
                    end
                end
                // forward to a line still in flight must wait
                if (mshr_hit_next) begin
                    set_fwd_stall = 1'b1;
                    set_fwd_stall_entry = 1'b1;
                    fwd_stall_entry = mshr_i_next;
                end else begin
                    clr_fwd_stall = 1'b1;
                end
            end
            default: begin
                // idle, everything stays low
                mshr_hit_next = 1'b0;
            end
        endcase
    end

    // result register, holds across idle cycles
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mshr_i <= '0;
            mshr_hit <= 1'b0;
        end else if (op != `L2_MSHR_IDLE) begin
            mshr_i <= mshr_i_next;
            mshr_hit <= mshr_hit_next;
        end
    end

endmodule

// File: mshr_table.sv
`include "l2_mshr_consts.svh"

module mshr_table import l2_mshr_pkg::*; (
    input logic clk,
    input logic rst,
    input logic add_entry,
    input logic update_state,
    input logic update_line,
    input logic update_tag,
    input logic update_word_mask,
    // address of the request being allocated
    input addr_t req_addr,
    // registered target index
    input mshr_index_t mshr_i,
    input cpu_msg_t cpu_msg,
    input l2_way_t way,
    input hsize_t hsize,
    input hprot_t hprot,
    input word_t word,
    input l2_tag_t tag,
    input line_t line,
    input word_mask_t word_mask,
    input unstable_state_t state,
    output mshr_buf_t entries [`N_MSHR]
);

    // request address fields
    l2_set_t req_set;
    w_off_t req_w_off;
    b_off_t req_b_off;

    // one-hot write select
    logic [`N_MSHR-1:0] sel;

    assign req_b_off = req_addr[`BYTE_BITS-1:0];
    assign req_w_off = req_addr[`BYTE_BITS +: `WORD_BITS];
    assign req_set = req_addr[`BYTE_BITS+`WORD_BITS +: `SET_BITS];

    // decode mshr_i
    always_comb begin
        for (int i = 0; i < `N_MSHR; i++) begin
            sel[i] = (mshr_i == mshr_index_t'(i));
        end
    end

    // values fan out to all entries, sel picks the writer
    for (genvar g = 0; g < `N_MSHR; g++) begin : g_entry
        mshr_entry u_entry (
            .clk(clk),
            .rst(rst),
            .sel(sel[g]),
            .add_entry(add_entry),
            .update_state(update_state),
            .update_line(update_line),
            .update_tag(update_tag),
            .update_word_mask(update_word_mask),
            .cpu_msg(cpu_msg),
            .set(req_set),
            .w_off(req_w_off),
            .b_off(req_b_off),
            .way(way),
            .hsize(hsize),
            .hprot(hprot),
            .word(word),
            .tag(tag),
            .line(line),
            .word_mask(word_mask),
            .state(state),
            .entry(entries[g])
        );
    end

endmodule

// File: tb_l2_mshr.sv
`include "l2_mshr_consts.svh"

module tb_l2_mshr import l2_mshr_pkg::*; ();

    localparam int CYCLES_PER_TEST = 40;
    localparam int N_TESTS = 6;
    // six tests plus reset and headroom
    localparam int MAX_CYCLES = CYCLES_PER_TEST * (N_TESTS + 4);

    logic clk;
    logic rst;
    mshr_op_t op;
    addr_t req_addr;
    addr_t line_addr;
    logic add_entry;
    logic update_state;
    logic update_line;
    logic update_tag;
    logic update_word_mask;
    cpu_msg_t cpu_msg;
    l2_way_t way;
    hsize_t hsize;
    hprot_t hprot;
    word_t word;
    l2_tag_t tag;
    line_t line;
    word_mask_t word_mask;
    unstable_state_t state;
    mshr_buf_t entries [`N_MSHR];
    logic mshr_hit_next;
    logic mshr_hit;
    mshr_index_t mshr_i_next;
    mshr_index_t mshr_i;
    logic set_conflict;
    logic clr_conflict;
    logic set_fwd_stall;
    logic clr_fwd_stall;
    logic set_fwd_stall_entry;
    mshr_index_t fwd_stall_entry;

    // expected table contents
    mshr_buf_t model [`N_MSHR];
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;

    l2_mshr dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hard stop, the run must never hang
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input mshr_index_t got, input mshr_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_entry(input string name, input mshr_buf_t got, input mshr_buf_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // whole table against the model
    task automatic check_table();
        for (int i = 0; i < `N_MSHR; i++) begin
            check_entry($sformatf("entries[%0d]", i), entries[i], model[i]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %-12s %s, %0d mismatches", name,
            (test_errors == 0) ? "passed" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    // fresh random write values on the next falling edge, state always live
    task automatic draw_values();
        @(negedge clk);
        cpu_msg = cpu_msg_t'($urandom);
        way = l2_way_t'($urandom);
        hsize = hsize_t'($urandom);
        hprot = hprot_t'($urandom);
        word = $urandom;
        tag = l2_tag_t'($urandom);
        line = {$urandom, $urandom, $urandom, $urandom};
        word_mask = word_mask_t'($urandom);
        state = unstable_state_t'($urandom_range(7, 1));
    endtask

    // both address ports get the address, each op reads only its own
    task automatic query(input mshr_op_t q, input addr_t a);
        @(negedge clk);
        op = q;
        req_addr = a;
        line_addr = a;
        // combinational search settles
        #5;
    endtask

    // one idle cycle, the previous query is registered by now
    task automatic idle_cycle();
        @(negedge clk);
        op = `L2_MSHR_IDLE;
    endtask

    // strobes for one cycle at the registered index
    task automatic write_strobes(input logic add, input logic st, input logic ln,
                                 input logic tg, input logic wm);
        idle_cycle();
        add_entry = add;
        update_state = st;
        update_line = ln;
        update_tag = tg;
        update_word_mask = wm;
        @(negedge clk);
        {add_entry, update_state, update_line, update_tag, update_word_mask} = '0;
    endtask

    // peek request for set s, expect slot idx, then add there
    task automatic allocate(input l2_set_t s, input mshr_index_t idx);
        w_off_t w;
        b_off_t b;
        draw_values();
        w = w_off_t'($urandom);
        b = b_off_t'($urandom);
        query(`L2_MSHR_PEEK_REQ, {tag, s, w, b});
        check_index("mshr_i_next", mshr_i_next, idx);
        model[idx] = '{cpu_msg: cpu_msg, tag: tag, set: s, way: way, hsize: hsize,
            w_off: w, b_off: b, hprot: hprot, word: word, line: line,
            word_mask: word_mask, state: state};
        write_strobes(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_reset();
        check_table();
        check_flag("mshr_hit", mshr_hit, 1'b0);
        check_index("mshr_i", mshr_i, '0);
        // empty table, top slot is free
        query(`L2_MSHR_PEEK_REQ, {l2_tag_t'($urandom), 8'h55, 4'h0});
        check_index("mshr_i_next", mshr_i_next, mshr_index_t'(`N_MSHR - 1));
        check_flag("clr_conflict", clr_conflict, 1'b1);
        check_flag("set_conflict", set_conflict, 1'b0);
        finish_test("reset_state");
    endtask

    task automatic test_alloc();
        allocate(8'h10, 2'd3);
        check_table();
        // next lower free slot
        allocate(8'h20, 2'd2);
        check_table();
        finish_test("allocation");
    endtask

    task automatic test_conflict();
        // same set as slot 3, other tag
        query(`L2_MSHR_PEEK_REQ, {model[3].tag ^ 20'h1, 8'h10, 4'h0});
        check_flag("set_conflict", set_conflict, 1'b1);
        check_flag("clr_conflict", clr_conflict, 1'b0);
        check_index("mshr_i_next", mshr_i_next, 2'd1);
        query(`L2_MSHR_PEEK_REQ, {model[3].tag, 8'h30, 4'h0});
        check_flag("set_conflict", set_conflict, 1'b0);
        check_flag("clr_conflict", clr_conflict, 1'b1);
        finish_test("set_conflict");
    endtask

    task automatic test_lookup();
        query(`L2_MSHR_LOOKUP, {model[3].tag, model[3].set, 4'h0});
        check_flag("mshr_hit_next", mshr_hit_next, 1'b1);
        idle_cycle();
        check_flag("mshr_hit", mshr_hit, 1'b1);
        check_index("mshr_i", mshr_i, 2'd3);
        // tag off by one bit
        query(`L2_MSHR_LOOKUP, {model[2].tag ^ 20'h80, model[2].set, 4'h0});
        idle_cycle();
        check_flag("mshr_hit", mshr_hit, 1'b0);
        finish_test("lookup");
    endtask

    task automatic test_updates();
        // point mshr_i at slot 2
        query(`L2_MSHR_LOOKUP, {model[2].tag, model[2].set, 4'h0});
        draw_values();
        write_strobes(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        model[2].line = line;
        check_table();
        draw_values();
        write_strobes(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        model[2].tag = tag;
        check_table();
        draw_values();
        write_strobes(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        model[2].word_mask = word_mask;
        check_table();
        draw_values();
        write_strobes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        model[2].state = state;
        check_table();
        // Invalid state frees the slot.
        state = `SPX_I;
        write_strobes(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        model[2].state = `SPX_I;
        check_table();
        query(`L2_MSHR_LOOKUP, {model[2].tag, model[2].set, 4'h0});
        idle_cycle();
        check_flag("mshr_hit", mshr_hit, 1'b0);
        finish_test("updates");
    endtask

    task automatic test_forward();
        query(`L2_MSHR_PEEK_FWD, {model[3].tag, model[3].set, 4'h0});
        check_flag("set_fwd_stall", set_fwd_stall, 1'b1);
        check_flag("set_fwd_stall_entry", set_fwd_stall_entry, 1'b1);
        check_index("fwd_stall_entry", fwd_stall_entry, 2'd3);
        check_flag("clr_fwd_stall", clr_fwd_stall, 1'b0);
        // slot 2 was freed
        query(`L2_MSHR_PEEK_FWD, {model[2].tag, model[2].set, 4'h0});
        check_flag("set_fwd_stall", set_fwd_stall, 1'b0);
        check_flag("set_fwd_stall_entry", set_fwd_stall_entry, 1'b0);
        check_flag("clr_fwd_stall", clr_fwd_stall, 1'b1);
        idle_cycle();
        finish_test("forward");
    endtask

    initial begin
        void'($urandom(89));
        rst = 1'b0;
        op = `L2_MSHR_IDLE;
        req_addr = '0;
        line_addr = '0;
        {add_entry, update_state, update_line, update_tag, update_word_mask} = '0;
        {cpu_msg, way, hsize, hprot, word, tag, line, word_mask, state} = '0;
        for (int i = 0; i < `N_MSHR; i++) begin
            model[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b1;
        test_reset();
        test_alloc();
        test_conflict();
        test_lookup();
        test_updates();
        test_forward();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
